// File: source/cornet_defs.svh
// Cornet CPU shared constants.
// Bus widths, the reset vector location and the zero-page prefix.

`ifndef CORNET_DEFS_SVH
`define CORNET_DEFS_SVH

// Address and data bus widths.
`define CORNET_ADDR_W 16
`define CORNET_DATA_W 8

// Low byte of the reset vector. The high byte follows at the next address.
`define CORNET_RESET_VECTOR 16'hFFFC

// High byte placed in front of a zero-page operand.
`define CORNET_ZP_PAGE 8'h00

`endif

// File: source/cornet_bus_pkg.sv
// Cornet bus types.
// Addresses, data bytes, the two-way operand word and the write record.

`include "cornet_defs.svh"

package cornet_bus_pkg;

   typedef logic [`CORNET_ADDR_W-1:0] addr_t;
   typedef logic [`CORNET_DATA_W-1:0] byte_t;

   // An operand is either a full absolute address or a byte in the low half.
   typedef union packed {
      addr_t abs;
      struct packed {
         byte_t hi;
         byte_t lo;
      } bytes;
   } operand_u;

   typedef struct packed {
      addr_t addr;
      byte_t data;
   } bus_write_t;

endpackage

// File: source/cornet_isa_pkg.sv
// Cornet instruction set types.
// Opcode values of the reduced 6502 subset and the decoded instruction record.

`include "cornet_defs.svh"

package cornet_isa_pkg;

   typedef enum logic [`CORNET_DATA_W-1:0] {
      OP_JMP_ABS = 8'h4C,
      OP_STA_ZP  = 8'h85,
      OP_TXA     = 8'h8A,
      OP_STA_ABS = 8'h8D,
      OP_LDY_IMM = 8'hA0,
      OP_LDX_IMM = 8'hA2,
      OP_LDA_ZP  = 8'hA5,
      OP_LDA_IMM = 8'hA9,
      OP_TAX     = 8'hAA,
      OP_LDA_ABS = 8'hAD,
      OP_CMP_IMM = 8'hC9,
      OP_DEX     = 8'hCA,
      OP_BNE     = 8'hD0,
      OP_CPX_IMM = 8'hE0,
      OP_INX     = 8'hE8,
      OP_BEQ     = 8'hF0
   } opcode_e;

   typedef enum logic [3:0] {
      CLS_NONE, CLS_LOAD, CLS_STORE, CLS_INC, CLS_DEC,
      CLS_TRANSFER, CLS_COMPARE, CLS_BRANCH, CLS_JUMP
   } op_class_e;

   typedef enum logic [1:0] {REG_A, REG_X, REG_Y} reg_sel_e;

   typedef enum logic [1:0] {
      MODE_IMPLIED, MODE_IMMEDIATE, MODE_ZERO_PAGE, MODE_ABSOLUTE
   } addr_mode_e;

   typedef struct packed {
      op_class_e  op_class;
      reg_sel_e   target;
      reg_sel_e   source;
      addr_mode_e mode;
      logic       branch_on_z;
      logic [1:0] length;
   } decoded_t;

endpackage

// File: source/cornet_decoder.sv
// Cornet opcode decoder.
// Maps an opcode byte to its operation class, registers, addressing mode
// and length. Opcodes outside the subset become one-byte no-operations.

`timescale 1ns/1ns

module cornet_decoder (
   input  cornet_bus_pkg::byte_t    opcode,
   output cornet_isa_pkg::decoded_t dec
);
   import cornet_isa_pkg::*;

   always_comb
   begin
      dec.op_class    = CLS_NONE;
      dec.target      = REG_A;
      dec.source      = REG_A;
      dec.mode        = MODE_IMPLIED;
      dec.branch_on_z = 1'b0;

      case (opcode)
         OP_LDA_IMM: {dec.op_class, dec.mode} = {CLS_LOAD, MODE_IMMEDIATE};
         OP_LDA_ZP:  {dec.op_class, dec.mode} = {CLS_LOAD, MODE_ZERO_PAGE};
         OP_LDA_ABS: {dec.op_class, dec.mode} = {CLS_LOAD, MODE_ABSOLUTE};
         OP_STA_ZP:  {dec.op_class, dec.mode} = {CLS_STORE, MODE_ZERO_PAGE};
         OP_STA_ABS: {dec.op_class, dec.mode} = {CLS_STORE, MODE_ABSOLUTE};
         OP_CMP_IMM: {dec.op_class, dec.mode} = {CLS_COMPARE, MODE_IMMEDIATE};
         OP_JMP_ABS: {dec.op_class, dec.mode} = {CLS_JUMP, MODE_ABSOLUTE};
         OP_LDX_IMM: {dec.op_class, dec.target, dec.mode} = {CLS_LOAD, REG_X, MODE_IMMEDIATE};
         OP_LDY_IMM: {dec.op_class, dec.target, dec.mode} = {CLS_LOAD, REG_Y, MODE_IMMEDIATE};
         OP_CPX_IMM: {dec.op_class, dec.target, dec.mode} = {CLS_COMPARE, REG_X, MODE_IMMEDIATE};
         OP_INX:     {dec.op_class, dec.target} = {CLS_INC, REG_X};
         OP_DEX:     {dec.op_class, dec.target} = {CLS_DEC, REG_X};
         OP_TAX:     {dec.op_class, dec.target, dec.source} = {CLS_TRANSFER, REG_X, REG_A};
         OP_TXA:     {dec.op_class, dec.target, dec.source} = {CLS_TRANSFER, REG_A, REG_X};
         OP_BEQ:
         begin
            {dec.op_class, dec.mode} = {CLS_BRANCH, MODE_IMMEDIATE};
            dec.branch_on_z          = 1'b1;
         end
         OP_BNE:     {dec.op_class, dec.mode} = {CLS_BRANCH, MODE_IMMEDIATE};
         default:    dec.op_class = CLS_NONE;
      endcase

      // Instruction length follows from the addressing mode alone.
      case (dec.mode)
         MODE_IMPLIED:  dec.length = 2'd1;
         MODE_ABSOLUTE: dec.length = 2'd3;
         default:       dec.length = 2'd2;
      endcase
   end

endmodule

// File: source/cornet_bus_unit.sv
// Cornet bus unit.
// Runs byte reads, two-byte word reads and byte writes on the external bus,
// one at a time. Read data is taken on the first later cycle with ready high.

`timescale 1ns/1ns

module cornet_bus_unit (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       rd_byte_req,
   input  logic                       rd_word_req,
   input  cornet_bus_pkg::addr_t      rd_addr,
   input  logic                       wr_req,
   input  cornet_bus_pkg::bus_write_t wr_rec,
   input  cornet_bus_pkg::byte_t      rd_data,
   input  logic                       ready,
   output logic                       rd_done,
   output cornet_bus_pkg::operand_u   rd_word,
   output cornet_bus_pkg::addr_t      addr,
   output cornet_bus_pkg::byte_t      wr_data,
   output logic                       wr_en,
   output logic                       rd_req
);
   import cornet_bus_pkg::*;

   typedef enum logic [1:0] {BUS_IDLE, BUS_BYTE, BUS_WORD_LO, BUS_WORD_HI} bus_state_e;

   bus_state_e state;
   logic       sample;

   // The cycle carrying the rd_req pulse never counts as a data cycle.
   assign sample = ready && !rd_req;

   always_ff @(posedge clk)
   begin
      rd_done <= 1'b0;
      rd_req  <= 1'b0;
      wr_en   <= 1'b0;
      if (!reset_n)
      begin
         state <= BUS_IDLE;
      end
      else
      begin
         case (state)
            BUS_IDLE:
               if (rd_byte_req || rd_word_req)
               begin
                  addr   <= rd_addr;
                  rd_req <= 1'b1;
                  state  <= rd_word_req ? BUS_WORD_LO : BUS_BYTE;
               end
               else if (wr_req)
               begin
                  addr    <= wr_rec.addr;
                  wr_data <= wr_rec.data;
                  wr_en   <= 1'b1;
               end
            BUS_BYTE:
               if (sample)
               begin
                  rd_word.bytes.hi <= '0;
                  rd_word.bytes.lo <= rd_data;
                  rd_done          <= 1'b1;
                  state            <= BUS_IDLE;
               end
            BUS_WORD_LO:
               if (sample)
               begin
                  rd_word.bytes.lo <= rd_data;
                  addr             <= addr + addr_t'(1);
                  rd_req           <= 1'b1;
                  state            <= BUS_WORD_HI;
               end
            default:
               if (sample)
               begin
                  rd_word.bytes.hi <= rd_data;
                  rd_done          <= 1'b1;
                  state            <= BUS_IDLE;
               end
         endcase
      end
   end

endmodule

// File: source/cornet_sequencer.sv
// Cornet fetch and execute sequencer.
// Reads the reset vector, then fetches opcodes, reads operands and memory
// through the bus unit and executes. Holds PC, A, X, Y and the Z flag.

`timescale 1ns/1ns
`include "cornet_defs.svh"

module cornet_sequencer (
   input  logic                       clk,
   input  logic                       reset_n,
   input  cornet_isa_pkg::decoded_t   dec,
   input  logic                       rd_done,
   input  cornet_bus_pkg::operand_u   rd_word,
   output cornet_bus_pkg::byte_t      opcode,
   output logic                       rd_byte_req,
   output logic                       rd_word_req,
   output cornet_bus_pkg::addr_t      rd_addr,
   output logic                       wr_req,
   output cornet_bus_pkg::bus_write_t wr_rec
);
   import cornet_bus_pkg::*;
   import cornet_isa_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE, S_VECTOR, S_FETCH, S_DECODE, S_OPERAND, S_MEMORY, S_EXECUTE
   } seq_state_e;

   seq_state_e state;
   addr_t      pc;
   addr_t      pc_next;
   addr_t      ea;
   addr_t      offset;
   byte_t      reg_a;
   byte_t      reg_x;
   byte_t      reg_y;
   byte_t      tgt_val;
   byte_t      src_val;
   byte_t      result;
   logic       z;
   logic       wr_target;
   operand_u   operand_q;

   // Effective address straight from the operand as it arrives.
   assign ea = (dec.mode == MODE_ZERO_PAGE) ? {`CORNET_ZP_PAGE, rd_word.bytes.lo} : rd_word.abs;

   assign offset = {{(`CORNET_ADDR_W-`CORNET_DATA_W){operand_q.bytes.lo[7]}},
                    operand_q.bytes.lo};

   always_comb
   begin
      tgt_val = (dec.target == REG_X) ? reg_x : (dec.target == REG_Y) ? reg_y : reg_a;
      src_val = (dec.source == REG_X) ? reg_x : (dec.source == REG_Y) ? reg_y : reg_a;
      wr_target = 1'b1;
      case (dec.op_class)
         CLS_LOAD:     result = operand_q.bytes.lo;
         CLS_INC:      result = tgt_val + byte_t'(1);
         CLS_DEC:      result = tgt_val - byte_t'(1);
         CLS_TRANSFER: result = src_val;
         default:
         begin
            result    = tgt_val;
            wr_target = 1'b0;
         end
      endcase

      pc_next = pc + addr_t'(dec.length);
      if (dec.op_class == CLS_JUMP)
         pc_next = operand_q.abs;
      else if (dec.op_class == CLS_BRANCH && (z == dec.branch_on_z))
         pc_next = pc + addr_t'(dec.length) + offset;
   end

   always_ff @(posedge clk)
   begin
      rd_byte_req <= 1'b0;
      rd_word_req <= 1'b0;
      wr_req      <= 1'b0;
      if (!reset_n)
      begin
         state <= S_IDLE;
         reg_a <= '0;
         reg_x <= '0;
         reg_y <= '0;
         z     <= 1'b0;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               rd_word_req <= 1'b1;
               rd_addr     <= `CORNET_RESET_VECTOR;
               state       <= S_VECTOR;
            end
            S_VECTOR:
               if (rd_done)
               begin
                  pc          <= rd_word.abs;
                  rd_byte_req <= 1'b1;
                  rd_addr     <= rd_word.abs;
                  state       <= S_FETCH;
               end
            S_FETCH:
               if (rd_done)
               begin
                  opcode <= rd_word.bytes.lo;
                  state  <= S_DECODE;
               end
            S_DECODE:
               if (dec.length == 2'd1)
               begin
                  state <= S_EXECUTE;
               end
               else
               begin
                  rd_word_req <= (dec.length == 2'd3);
                  rd_byte_req <= (dec.length != 2'd3);
                  rd_addr     <= pc + addr_t'(1);
                  state       <= S_OPERAND;
               end
            S_OPERAND:
               if (rd_done)
               begin
                  operand_q <= rd_word;
                  state     <= S_EXECUTE;
                  if (dec.op_class == CLS_STORE)
                  begin
                     wr_req <= 1'b1;
                     wr_rec <= '{addr: ea, data: reg_a};
                  end
                  else if (dec.op_class == CLS_LOAD && dec.mode != MODE_IMMEDIATE)
                  begin
                     rd_byte_req <= 1'b1;
                     rd_addr     <= ea;
                     state       <= S_MEMORY;
                  end
               end
            S_MEMORY:
               if (rd_done)
               begin
                  operand_q <= rd_word;
                  state     <= S_EXECUTE;
               end
            default:
            begin
               if (wr_target)
               begin
                  case (dec.target)
                     REG_X:   reg_x <= result;
                     REG_Y:   reg_y <= result;
                     default: reg_a <= result;
                  endcase
                  z <= (result == '0);
               end
               else if (dec.op_class == CLS_COMPARE)
               begin
                  z <= (tgt_val == operand_q.bytes.lo);
               end
               // The next opcode fetch closes this instruction.
               pc          <= pc_next;
               rd_byte_req <= 1'b1;
               rd_addr     <= pc_next;
               state       <= S_FETCH;
            end
         endcase
      end
   end

endmodule

// File: source/cornet_cpu.sv
// Cornet CPU top level.
// Reduced 6502-style CPU for bus testing, built from decoder, sequencer and bus unit.

`timescale 1ns/1ns

module cornet_cpu (
   input  logic                  clk,
   input  logic                  reset_n,
   output cornet_bus_pkg::addr_t addr,
   input  cornet_bus_pkg::byte_t rd_data,
   output cornet_bus_pkg::byte_t wr_data,
   output logic                  wr_en,
   output logic                  rd_req,
   input  logic                  ready
);

   cornet_isa_pkg::decoded_t   dec;
   cornet_bus_pkg::byte_t      opcode;
   cornet_bus_pkg::addr_t      rd_addr;
   cornet_bus_pkg::operand_u   rd_word;
   cornet_bus_pkg::bus_write_t wr_rec;
   logic                       rd_byte_req;
   logic                       rd_word_req;
   logic                       wr_req;
   logic                       rd_done;

   cornet_decoder u_decoder (
      .opcode (opcode),
      .dec    (dec)
   );

   cornet_sequencer u_sequencer (
      .clk         (clk),
      .reset_n     (reset_n),
      .dec         (dec),
      .rd_done     (rd_done),
      .rd_word     (rd_word),
      .opcode      (opcode),
      .rd_byte_req (rd_byte_req),
      .rd_word_req (rd_word_req),
      .rd_addr     (rd_addr),
      .wr_req      (wr_req),
      .wr_rec      (wr_rec)
   );

   cornet_bus_unit u_bus_unit (
      .clk         (clk),
      .reset_n     (reset_n),
      .rd_byte_req (rd_byte_req),
      .rd_word_req (rd_word_req),
      .rd_addr     (rd_addr),
      .wr_req      (wr_req),
      .wr_rec      (wr_rec),
      .rd_data     (rd_data),
      .ready       (ready),
      .rd_done     (rd_done),
      .rd_word     (rd_word),
      .addr        (addr),
      .wr_data     (wr_data),
      .wr_en       (wr_en),
      .rd_req      (rd_req)
   );

endmodule

// File: testbench/cornet_assert.sv
// Cornet bus strobe checks.
// Bound into the CPU top level, where it watches rd_req and wr_en.

`timescale 1ns/1ns

module cornet_assert (
   input logic clk,
   input logic reset_n,
   input logic rd_req,
   input logic wr_en
);
   int fail_count = 0;

   // A read strobe and a write strobe never share a cycle.
   strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req && wr_en))
   else
   begin
      fail_count++;
      $error("rd_req and wr_en are high in the same cycle");
   end

   // The strobes are cleared by the first reset edge and stay low.
   strobes_low_in_reset: assert property (@(posedge clk)
      !reset_n |=> (!rd_req && !wr_en))
   else
   begin
      fail_count++;
      $error("bus strobe active while reset_n is low");
   end

   // A read request is a single-cycle pulse.
   rd_req_single: assert property (@(posedge clk) disable iff (!reset_n)
      rd_req |=> !rd_req)
   else
   begin
      fail_count++;
      $error("rd_req held high for two cycles");
   end

endmodule

bind cornet_cpu cornet_assert u_assert (
   .clk     (clk),
   .reset_n (reset_n),
   .rd_req  (rd_req),
   .wr_en   (wr_en)
);

// File: testbench/cornet_tb.sv
// Cornet CPU testbench.
// Runs the program image from the pattern file under random ready stalls
// and checks every bus write against the expected write list.

`timescale 1ns/1ns

module cornet_tb;
   import cornet_bus_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 4;
   localparam int DRAIN_CYCLES = 200;
   localparam int REC_MAX      = 256;

   logic        clk;
   logic        reset_n;
   addr_t       addr;
   byte_t       rd_data;
   byte_t       wr_data;
   logic        wr_en;
   logic        rd_req;
   logic        ready;

   logic [31:0] records [0:REC_MAX-1];
   byte_t       mem [0:65535];
   bus_write_t  exp_q [$];
   int          exp_test_q [$];
   int          pending [0:15];
   int          test_errors [0:15];
   int          remaining;
   int          image_bytes;
   int          errors;
   int          tests_passed;
   int          tests_failed;
   int          cycle;
   int          limit;
   logic        timed_out;
   logic        ready_next;
   logic [31:0] rng;
   addr_t       rd_addr_q;

   cornet_cpu dut_i (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic logic [31:0] next_random(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic load_patterns();
      bus_write_t w;
      int         test;
      int         i;
      for (i = 0; i < 65536; i++)
         mem[i] = byte_t'(i[15:8] ^ i[7:0] ^ 8'h3C);
      for (i = 0; i < REC_MAX; i++)
         records[i] = '0;
      $readmemh("testbench/cornet_patterns.mem", records);
      // Record layout is kind, test number, address and byte.
      for (i = 0; i < REC_MAX; i++)
      begin
         case (records[i][31:28])
            4'h1:
            begin
               mem[records[i][23:8]] = records[i][7:0];
               image_bytes++;
            end
            4'h2:
            begin
               w.addr = records[i][23:8];
               w.data = records[i][7:0];
               test   = int'(records[i][27:24]);
               exp_q.push_back(w);
               exp_test_q.push_back(test);
               pending[test]++;
            end
            default: ;
         endcase
      end
      remaining = exp_q.size();
   endtask

   task automatic check_addr(input int test, input string name, input addr_t expected,
                             input addr_t actual);
      if (actual !== expected)
      begin
         $display("** Error: test %0d %s expected %h, got %h", test, name, expected, actual);
         test_errors[test]++;
         errors++;
      end
   endtask

   task automatic check_byte(input int test, input string name, input byte_t expected,
                             input byte_t actual);
      if (actual !== expected)
      begin
         $display("** Error: test %0d %s expected %h, got %h", test, name, expected, actual);
         test_errors[test]++;
         errors++;
      end
   endtask

   task automatic close_test(input int test);
      if (test_errors[test] == 0)
      begin
         $display("Test %0d passed", test);
         tests_passed++;
      end
      else
      begin
         $display("Test %0d failed with %0d errors", test, test_errors[test]);
         tests_failed++;
      end
   endtask

   task automatic match_write(input bus_write_t seen);
      bus_write_t want;
      int         test;
      if (remaining == 0)
      begin
         $display("Unexpected write of %h to address %h after the last expected write",
                  seen.data, seen.addr);
         errors++;
      end
      else
      begin
         want = exp_q.pop_front();
         test = exp_test_q.pop_front();
         remaining--;
         check_addr(test, "addr", want.addr, seen.addr);
         check_byte(test, "wr_data", want.data, seen.data);
         pending[test]--;
         if (pending[test] == 0)
            close_test(test);
      end
   endtask

   task automatic report_missing();
      int t;
      $display("Timeout after %0d cycles with %0d expected writes missing", cycle, remaining);
      errors++;
      for (t = 0; t < 16; t++)
      begin
         if (pending[t] != 0)
         begin
            $display("Test %0d failed, %0d of its writes never arrived", t, pending[t]);
            tests_failed++;
         end
      end
   endtask

   // Memory model. Read data is valid only in cycles where ready is high,
   // otherwise the data lines carry its complement.
   always @(posedge clk)
   begin
      bus_write_t seen;
      rng        = next_random(rng);
      ready_next = (rng[1:0] != 2'b00);
      if (rd_req)
         rd_addr_q = addr;
      ready   <= ready_next;
      rd_data <= ready_next ? mem[rd_addr_q] : ~mem[rd_addr_q];
      if (wr_en)
      begin
         seen.addr = addr;
         seen.data = wr_data;
         mem[addr] = wr_data;
         match_write(seen);
      end
      if (reset_n)
         cycle++;
      if (cycle >= limit && remaining != 0 && !timed_out)
      begin
         report_missing();
         timed_out = 1'b1;
      end
   end

   initial
   begin
      clk        = 1'b0;
      reset_n   <= 1'b0;
      rd_data   <= '0;
      ready     <= 1'b1;
      rng        = 32'hf2d4_004c;
      rd_addr_q  = '0;
      timed_out  = 1'b0;
      load_patterns();
      limit = 80 * image_bytes + 40 * remaining;
      repeat (RESET_CYCLES) @(posedge clk);
      reset_n <= 1'b1;
      while (remaining != 0 && !timed_out)
         @(negedge clk);
      // Keep running a while so that stray writes are caught.
      if (!timed_out)
         repeat (DRAIN_CYCLES) @(negedge clk);
      if (dut_i.u_assert.fail_count != 0)
      begin
         $display("%0d bus strobe assertions failed", dut_i.u_assert.fail_count);
         errors++;
      end
      $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: testbench/cornet_patterns.mem
// Records of eight hex digits: kind, test number, address (4 digits), byte (2 digits).
// Kind 1 is a program image byte, kind 2 an expected write tagged with its test.
10FFFC00 10FFFD02                     // reset vector points to 0200
100200A9 1002015A                     // 0200 LDA #$5A
10020285 10020310                     // 0202 STA $10
100204A2 10020521                     // 0204 LDX #$21
1002068A 10020785 10020811            // 0206 TXA, STA $11
100209A5 10020A10                     // 0209 LDA $10
10020B8D 10020C00 10020D03            // 020B STA $0300
10020EAD 10020F80 10021002            // 020E LDA $0280
10021185 10021212                     // 0211 STA $12
100213A9 1002147E                     // 0213 LDA #$7E
1002158D 10021601 10021703            // 0215 STA $0301
100218A2 10021903                     // 0218 LDX #$03
10021A8A 10021B85 10021C20 10021DCA   // 021A loop TXA, STA $20, DEX
10021ED0 10021FFA                     // 021E BNE loop
1002208A 10022185 10022220            // 0220 TXA, STA $20
100223A9 10022440 100225C9 10022640   // 0223 LDA #$40, CMP #$40
100227F0 10022802 10022985 10022A30   // 0227 BEQ +2 taken over STA $30
10022BC9 10022C41 10022DF0 10022E02   // 022B CMP #$41, BEQ +2 not taken
10022F85 10023031                     // 022F STA $31
100231D0 10023202 10023385 10023432   // 0231 BNE +2 taken over STA $32
100235A2 10023605 100237E0 10023805   // 0235 LDX #$05, CPX #$05
100239D0 10023A02 10023B85 10023C33   // 0239 BNE +2 not taken, STA $33
10023DE0 10023E06 10023FF0 10024002   // 023D CPX #$06, BEQ +2 not taken
10024185 10024234                     // 0241 STA $34
1002434C 1002444D 10024502            // 0243 JMP $024D
100246A9 10024799 10024885 10024935   // 0246 back LDA #$99, STA $35
10024A4C 10024B4A 10024C02            // 024A JMP $024A ends the program
10024DA0 10024E00 10024FF0 100250F5   // 024D LDY #$00, BEQ back
100280C3                              // data byte for LDA $0280
2100105A                              // test 1 reset vector
22001121 2203005A 220012C3 2203017E   // test 2 loads and stores
23002003 23002002 23002001 23002000   // test 3 counted loop
24003140 24003340 24003440 24003599   // test 4 compare and branch

// File: all.f
+incdir+source
source/cornet_bus_pkg.sv
source/cornet_isa_pkg.sv
source/cornet_decoder.sv
source/cornet_bus_unit.sv
source/cornet_sequencer.sv
source/cornet_cpu.sv
testbench/cornet_assert.sv
testbench/cornet_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the Cornet CPU.

VERILATOR ?= verilator
TOP       ?= cornet_tb
RTL_TOP   ?= cornet_cpu
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation passed

RTL_SRCS := $(shell grep '^source/.*\.sv$$' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+source $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
